//--- src/firDecim_settings.svh
`ifndef FIRDECIM_SETTINGS_SVH
`define FIRDECIM_SETTINGS_SVH

// Modulator code width
`define N 2

// Codes per output frame
`define OSR 4

// Window lengths in codes
`define LOOKAHEAD 8
`define LOOKBACK 8

// Address bits per LUT, a multiple of N
`define LUT_SIZE 4

// Adder layers between tree registers
`define COMB_ADDERS 1

// Coefficient and output scaling
`define COEF_W 12
`define COEF_SHIFT 6
`define OUT_W 14

`endif

//--- src/firDecimPkg.sv
`include "firDecim_settings.svh"

package firDecimPkg;

    typedef logic [`N-1:0] codeT;
    typedef logic signed [`N+1:0] levelT;
    typedef logic signed [`COEF_W-1:0] coefT;
    typedef logic signed [`COEF_W+`N+7:0] accT;
    typedef logic [`OUT_W-1:0] outT;

    // Step of the triangular taps
    localparam int COEF_BASE = 64;

    // Odd levels symmetric about zero
    function automatic levelT codeLevel(codeT code);
        int level;
        level = 2 * int'(code) - ((1 << `N) - 1);
        return levelT'(level);
    endfunction

    // Largest tap at index 0 of each window
    function automatic coefT tapCoef(bit isAhead, int index);
        int len;
        int value;
        len = isAhead ? `LOOKAHEAD : `LOOKBACK;
        value = COEF_BASE * (len - index);
        return coefT'(value);
    endfunction

endpackage

//--- src/sampleCollector.sv
`include "firDecim_settings.svh"

module sampleCollector (
    input  logic clkDS,
    input  logic rst,
    input  firDecimPkg::codeT codeIn,
    output firDecimPkg::codeT [`OSR-1:0] frame,
    output logic frameStrobe
);
    import firDecimPkg::*;

    localparam int PhaseW = (`OSR > 1) ? $clog2(`OSR) : 1;
    localparam logic [PhaseW-1:0] LastPhase = PhaseW'(`OSR - 1);

    logic [PhaseW-1:0] phase;
    codeT [`OSR-1:0] slots;
    codeT [`OSR-1:0] nextFrame;

    // Current code lands in its slot
    always_comb begin
        nextFrame = slots;
        nextFrame[phase] = codeIn;
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            phase <= '0;
            frameStrobe <= 1'b0;
        end else begin
            frameStrobe <= (phase == LastPhase);
            if (phase == LastPhase) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    always_ff @(posedge clkDS) begin
        slots <= nextFrame;
        if (phase == LastPhase) begin
            frame <= nextFrame;
        end
    end

    // One strobe per OSR cycles, never back to back
    frameStrobeGap: assert property (
        @(posedge clkDS) disable iff (!rst)
        (frameStrobe && (`OSR > 1)) |=> !frameStrobe
    );

endmodule

//--- src/historyShifter.sv
`include "firDecim_settings.svh"

module historyShifter (
    input  logic clkDS,
    input  logic rst,
    input  firDecimPkg::codeT [`OSR-1:0] frame,
    input  logic frameStrobe,
    output firDecimPkg::codeT [`LOOKAHEAD-1:0] windowAhead,
    output firDecimPkg::codeT [`LOOKBACK-1:0] windowBack,
    output logic windowStrobe
);
    import firDecimPkg::*;

    localparam int LookTotal = `LOOKAHEAD + `LOOKBACK;

    // Newest code at the top index, oldest at index 0
    codeT [LookTotal-1:0] history;

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            history <= '0;
            windowStrobe <= 1'b0;
        end else begin
            windowStrobe <= frameStrobe;
            if (frameStrobe) begin
                history <= {frame, history[LookTotal-1:`OSR]};
            end
        end
    end

    // Lookback runs oldest first
    assign windowBack = history[`LOOKBACK-1:0];

    // Lookahead reversed, newest first
    for (genvar i = 0; i < `LOOKAHEAD; i++) begin : gAhead
        assign windowAhead[i] = history[LookTotal-1-i];
    end

endmodule

//--- src/lutMacUnit.sv
`include "firDecim_settings.svh"

module lutMacUnit #(
    parameter int Size = 8,
    parameter bit IsAhead = 1'b0
) (
    input  logic clkDS,
    input  logic rst,
    input  firDecimPkg::codeT [Size-1:0] window,
    input  logic inStrobe,
    output firDecimPkg::accT result,
    output logic resultStrobe
);
    import firDecimPkg::*;

    localparam int CodesPerLut = `LUT_SIZE / `N;
    localparam int AddrW = CodesPerLut * `N;
    localparam int LutDepth = 1 << AddrW;
    localparam int NumLuts = (Size + CodesPerLut - 1) / CodesPerLut;
    localparam int PadW = NumLuts * AddrW;
    localparam int Layers = $clog2(NumLuts);
    localparam int Leaves = 1 << Layers;
    // Lookup register plus one register per group of layers
    localparam int Depth = 1 + (Layers + `COMB_ADDERS - 1) / `COMB_ADDERS;

    // Weighted sum of the codes one address covers
    function automatic accT lutEntry(int lutIdx, int addr);
        accT total;
        int tap;
        codeT code;
        total = '0;
        for (int c = 0; c < CodesPerLut; c++) begin
            tap = lutIdx * CodesPerLut + c;
            code = codeT'(addr >> (c * `N));
            if (tap < Size) begin
                total += accT'(tapCoef(IsAhead, tap)) * accT'(codeLevel(code));
            end
        end
        return total;
    endfunction

    logic [PadW-1:0] selBits;
    accT lutMem [NumLuts][LutDepth];
    accT lutOut [NumLuts];
    accT node [Layers+1][Leaves];
    logic [Depth-1:0] strobePipe;

    // Last group padded with zero bits
    assign selBits = PadW'(window);

    for (genvar g = 0; g < NumLuts; g++) begin : gLut
        for (genvar a = 0; a < LutDepth; a++) begin : gEntry
            localparam accT Entry = lutEntry(g, a);
            assign lutMem[g][a] = Entry;
        end

        always_ff @(posedge clkDS) begin
            lutOut[g] <= lutMem[g][selBits[g*AddrW +: AddrW]];
        end
    end

    // Tree leaves, unused ones tied to zero
    for (genvar k = 0; k < Leaves; k++) begin : gLeaf
        if (k < NumLuts) begin : gUsed
            assign node[0][k] = lutOut[k];
        end else begin : gPad
            assign node[0][k] = '0;
        end
    end

    for (genvar l = 1; l <= Layers; l++) begin : gLayer
        for (genvar k = 0; k < (Leaves >> l); k++) begin : gNode
            if ((l % `COMB_ADDERS == 0) || (l == Layers)) begin : gReg
                always_ff @(posedge clkDS) begin
                    node[l][k] <= node[l-1][2*k] + node[l-1][2*k+1];
                end
            end else begin : gComb
                assign node[l][k] = node[l-1][2*k] + node[l-1][2*k+1];
            end
        end
    end

    assign result = node[Layers][0];

    // Strobe travels alongside the tree
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            strobePipe <= '0;
        end else begin
            strobePipe <= Depth'({strobePipe, inStrobe});
        end
    end

    assign resultStrobe = strobePipe[Depth-1];

    resultLatency: assert property (
        @(posedge clkDS) disable iff (!rst)
        inStrobe |-> ##Depth resultStrobe
    );

endmodule

//--- src/outputScaler.sv
`include "firDecim_settings.svh"

module outputScaler (
    input  logic clkDS,
    input  logic rst,
    input  firDecimPkg::accT aheadResult,
    input  firDecimPkg::accT backResult,
    input  logic inStrobe,
    output firDecimPkg::outT outWord,
    output logic outStrobe,
    output logic valid
);
    import firDecimPkg::*;

    localparam int SumW = $bits(accT) + 1;
    localparam int LookTotal = `LOOKAHEAD + `LOOKBACK;
    // First frame whose window holds only real codes
    localparam int ValidFrame = (LookTotal + `OSR - 1) / `OSR;
    localparam int CountW = $clog2(ValidFrame + 1);
    localparam logic signed [SumW-1:0] MaxOut = (1 <<< (`OUT_W - 1)) - 1;
    localparam logic signed [SumW-1:0] MinOut = -(1 <<< (`OUT_W - 1));

    logic signed [SumW-1:0] sum;
    logic signed [SumW-1:0] shifted;
    logic signed [`OUT_W-1:0] sat;
    logic [CountW-1:0] frameCount;

    assign sum = aheadResult + backResult;
    assign shifted = sum >>> `COEF_SHIFT;

    always_comb begin
        if (shifted > MaxOut) begin
            sat = MaxOut[`OUT_W-1:0];
        end else if (shifted < MinOut) begin
            sat = MinOut[`OUT_W-1:0];
        end else begin
            sat = shifted[`OUT_W-1:0];
        end
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            outWord <= '0;
            outStrobe <= 1'b0;
            valid <= 1'b0;
            frameCount <= '0;
        end else begin
            outStrobe <= inStrobe;
            if (inStrobe) begin
                // Two's complement to offset binary
                outWord <= {~sat[`OUT_W-1], sat[`OUT_W-2:0]};
            end
            if (inStrobe && !valid) begin
                frameCount <= frameCount + 1'b1;
                if (frameCount == CountW'(ValidFrame - 1)) begin
                    valid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- src/firDecimTop.sv
`include "firDecim_settings.svh"

module firDecimTop (
    input  logic clkDS,
    input  logic rst,
    input  firDecimPkg::codeT codeIn,
    output firDecimPkg::outT outWord,
    output logic outStrobe,
    output logic valid
);
    import firDecimPkg::*;

    codeT [`OSR-1:0] frame;
    logic frameStrobe;
    codeT [`LOOKAHEAD-1:0] windowAhead;
    codeT [`LOOKBACK-1:0] windowBack;
    logic windowStrobe;
    accT aheadResult;
    accT backResult;
    logic aheadStrobe;
    logic backStrobe;

    sampleCollector collector (
        .clkDS(clkDS),
        .rst(rst),
        .codeIn(codeIn),
        .frame(frame),
        .frameStrobe(frameStrobe)
    );

    historyShifter shifter (
        .clkDS(clkDS),
        .rst(rst),
        .frame(frame),
        .frameStrobe(frameStrobe),
        .windowAhead(windowAhead),
        .windowBack(windowBack),
        .windowStrobe(windowStrobe)
    );

    lutMacUnit #(.Size(`LOOKAHEAD), .IsAhead(1'b1)) aheadMac (
        .clkDS(clkDS),
        .rst(rst),
        .window(windowAhead),
        .inStrobe(windowStrobe),
        .result(aheadResult),
        .resultStrobe(aheadStrobe)
    );

    lutMacUnit #(.Size(`LOOKBACK), .IsAhead(1'b0)) backMac (
        .clkDS(clkDS),
        .rst(rst),
        .window(windowBack),
        .inStrobe(windowStrobe),
        .result(backResult),
        .resultStrobe(backStrobe)
    );

    // Both units share the same depth when the windows match
    outputScaler scaler (
        .clkDS(clkDS),
        .rst(rst),
        .aheadResult(aheadResult),
        .backResult(backResult),
        .inStrobe(aheadStrobe & backStrobe),
        .outWord(outWord),
        .outStrobe(outStrobe),
        .valid(valid)
    );

endmodule

//--- dv/firDecimTb.sv
`include "firDecim_settings.svh"

module firDecimTb;
    import firDecimPkg::*;

    localparam int ClkPeriod = 8;
    localparam int ResetCycles = 10;
    // Edges from the last code of a frame to the check that sees its outStrobe
    localparam int StrobeLag = 6;
    localparam int ValidFrame = (`LOOKAHEAD + `LOOKBACK + `OSR - 1) / `OSR;
    localparam int MaxTests = 16;

    logic clkDS;
    logic rst;
    codeT codeIn;
    outT outWord;
    logic outStrobe;
    logic valid;

    outT expWord[$];
    int expTest[$];
    logic [8*24-1:0] testName [MaxTests];
    int pending [MaxTests];
    int wordsChecked [MaxTests];
    int mismatches [MaxTests];
    bit readDone [MaxTests];
    int testIdx;
    int checks;
    int errors;
    int sinceReset;
    bit resetSeen;
    int cycleCount;
    int cycleLimit;
    int traceCycles;

    firDecimTop u_dut (
        .clkDS(clkDS),
        .rst(rst),
        .codeIn(codeIn),
        .outWord(outWord),
        .outStrobe(outStrobe),
        .valid(valid)
    );

    initial begin
        clkDS = 1'b0;
        forever begin
            #(ClkPeriod / 2) clkDS = ~clkDS;
        end
    end

    function automatic void reportTest(int t);
        if (readDone[t] && pending[t] == 0) begin
            $display("test %0s: %0d words checked, %0d mismatches",
                testName[t], wordsChecked[t], mismatches[t]);
        end
    endfunction

    task automatic startTest(logic [8*24-1:0] name);
        if (testIdx >= 0) begin
            readDone[testIdx] = 1'b1;
            reportTest(testIdx);
        end
        testIdx++;
        testName[testIdx] = name;
    endtask

    task automatic driveCode(int code);
        codeIn <= codeT'(code);
        @(posedge clkDS);
    endtask

    // Drain pending outputs before pulsing reset
    task automatic applyReset();
        while (expWord.size() != 0) begin
            @(negedge clkDS);
        end
        @(posedge clkDS);
        rst <= 1'b0;
        repeat (ResetCycles) @(posedge clkDS);
        rst <= 1'b1;
    endtask

    task automatic readTrace(bit drive);
        int fd;
        int rc;
        int code;
        int word;
        logic [8*24-1:0] kind;
        logic [8*24-1:0] name;
        logic [8*128-1:0] rest;
        fd = $fopen("dv/firDecimTrace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/firDecimTrace.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                rc = $fgets(rest, fd);
            end else if (kind == "T") begin
                rc = $fscanf(fd, "%s", name);
                if (drive) begin
                    startTest(name);
                end
            end else if (kind == "F") begin
                for (int k = 0; k < `OSR; k++) begin
                    rc = $fscanf(fd, "%d", code);
                    if (drive) begin
                        driveCode(code);
                    end else begin
                        traceCycles += 1;
                    end
                end
            end else if (kind == "E") begin
                rc = $fscanf(fd, "%h", word);
                if (drive) begin
                    expWord.push_back(outT'(word));
                    expTest.push_back(testIdx);
                    pending[testIdx]++;
                end
            end else if (kind == "R") begin
                if (drive) begin
                    applyReset();
                end else begin
                    traceCycles += ResetCycles + StrobeLag + 1;
                end
            end else if (drive) begin
                $display("unknown record %0s in the trace file", kind);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic checkOutput(int edgeNo);
        bit expStrobe;
        int frameNo;
        int t;
        outT want;
        expStrobe = (edgeNo >= StrobeLag + `OSR) && ((edgeNo - StrobeLag) % `OSR == 0);
        frameNo = (edgeNo - StrobeLag) / `OSR;
        checks++;
        if (outStrobe !== expStrobe) begin
            $display("error at %0t: outStrobe expected %0d actual %0d",
                $time, expStrobe, outStrobe);
            errors++;
        end
        // Nothing leaves the DUT before the first frame is through
        if (edgeNo < StrobeLag + `OSR) begin
            checks++;
            if (outWord !== '0 || valid !== 1'b0) begin
                $display("error at %0t: outWord/valid expected 0 actual 0x%h/%0d",
                    $time, outWord, valid);
                errors++;
            end
        end
        if (outStrobe) begin
            checks++;
            if (valid !== (frameNo >= ValidFrame)) begin
                $display("error at %0t: valid expected %0d actual %0d",
                    $time, frameNo >= ValidFrame, valid);
                errors++;
            end
        end
        if (outStrobe && valid) begin
            if (expWord.size() == 0) begin
                $display("an output arrived at %0t with no expected word left", $time);
                errors++;
            end else begin
                want = expWord.pop_front();
                t = expTest.pop_front();
                checks++;
                wordsChecked[t]++;
                pending[t]--;
                if (outWord !== want) begin
                    $display("error at %0t: outWord expected 0x%h actual 0x%h",
                        $time, want, outWord);
                    errors++;
                    mismatches[t]++;
                end
                reportTest(t);
            end
        end
    endtask

    always @(posedge clkDS) begin
        resetSeen <= !rst;
        if (!rst) begin
            sinceReset <= 0;
        end else begin
            sinceReset <= sinceReset + 1;
            checkOutput(sinceReset + 1);
        end
    end

    // Outputs must be cleared by every reset edge
    always @(negedge clkDS) begin
        if (resetSeen) begin
            checks++;
            if (outWord !== '0 || outStrobe !== 1'b0 || valid !== 1'b0) begin
                $display("error at %0t: outWord/outStrobe/valid expected 0 actual 0x%h/%0d/%0d",
                    $time, outWord, outStrobe, valid);
                errors++;
            end
        end
    end

    initial begin
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clkDS);
            cycleCount++;
        end
        $display("timeout: the run went past its limit of %0d cycles", cycleLimit);
        if (expWord.size() != 0) begin
            $display("%0d expected words never met an output", expWord.size());
        end
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst = 1'b0;
        codeIn = '0;
        testIdx = -1;
        readTrace(1'b0);
        cycleLimit = ResetCycles + traceCycles + 64;
        repeat (ResetCycles) @(posedge clkDS);
        rst <= 1'b1;
        readTrace(1'b1);
        if (testIdx >= 0) begin
            readDone[testIdx] = 1'b1;
            reportTest(testIdx);
        end
        while (expWord.size() != 0) begin
            @(negedge clkDS);
        end
        $display("summary: %0d tests, %0d checks, %0d errors", testIdx + 1, checks, errors);
        if (errors == 0 && testIdx >= 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- dv/firDecimTrace.txt
# T name starts a test, F gives the OSR codes of one frame oldest first, R pulses reset
# E is the expected offset-binary outWord in hex for the next valid output
T constant
F 2 2 2 2
F 2 2 2 2
F 2 2 2 2
F 2 2 2 2
E 2048
F 2 2 2 2
E 2048
T alternate
R
F 1 2 1 2
F 1 2 1 2
F 1 2 1 2
F 1 2 1 2
E 2000
F 2 1 2 1
E 1ffc
T impulse
R
F 0 0 0 0
F 0 0 0 0
F 0 0 0 0
F 0 0 0 3
E 1f58
F 0 0 0 0
E 1f40
F 0 0 0 0
E 1f2e
F 0 0 0 0
E 1f46
F 0 0 0 0
E 1f28
T saturation
R
F 3 3 3 3
F 3 3 3 3
F 3 3 3 3
F 3 3 3 3
E 20d8
F 0 0 0 0
E 203c
F 0 0 0 0
E 2000
F 0 0 0 0
E 1fc4
F 0 0 0 0
E 1f28
T midReset
F 3 3 3 3
E 1fc4
F 3 3 3 3
E 2000
R
F 2 2 2 2
F 2 2 2 2
F 2 2 2 2
F 2 2 2 2
E 2048

//--- vlog.f
+incdir+src
src/firDecimPkg.sv
src/sampleCollector.sv
src/historyShifter.sv
src/lutMacUnit.sv
src/outputScaler.sv
src/firDecimTop.sv
dv/firDecimTb.sv

//--- Bender.yml
package:
  name: firDecim

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/firDecimPkg.sv
      - src/sampleCollector.sv
      - src/historyShifter.sv
      - src/lutMacUnit.sv
      - src/outputScaler.sv
      - src/firDecimTop.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - dv/firDecimTb.sv
